/* rtl/dma_pkg.sv */
package dma_pkg;

    localparam int DATA_W     = 32;
    localparam int PADDR_W    = 32;
    localparam int WORD_AW    = 16;          // word index, address bits 17:2
    localparam int BE_W       = DATA_W / 8;
    localparam int SIZE_W     = 16;
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_LVL_W = 3;           // holds 0..FIFO_DEPTH
    localparam int BANK_BIT   = 20;          // 1 selects mem0, 0 selects mem1

    //////////////////////////////////////////////////////////////////////
    // APB register map
    //////////////////////////////////////////////////////////////////////
    localparam logic [PADDR_W-1:0] REG_SRC  = 32'h0000_0000;
    localparam logic [PADDR_W-1:0] REG_DST  = 32'h0000_0004;
    localparam logic [PADDR_W-1:0] REG_SIZE = 32'h0000_0008;
    localparam logic [PADDR_W-1:0] REG_MODE = 32'h0000_000c;
    localparam logic [PADDR_W-1:0] REG_INT  = 32'h0000_0010;

    // byte lane masks
    localparam logic [BE_W-1:0] BE_ALL  = '1;
    localparam logic [BE_W-1:0] BE_NONE = '0;

    // byte address as software writes it, or split for the engines
    typedef union packed {
        logic [DATA_W-1:0] raw;
        struct packed {
            logic [DATA_W-BANK_BIT-2:0] unused_hi;    // 31:21
            logic                       bank;
            logic [1:0]                 unused_lo;    // 19:18
            logic [WORD_AW-1:0]         word;
            logic [1:0]                 offset;
        } f;
    } dma_addr_u;

endpackage

/* rtl/dma_apb_regs.sv */
`timescale 1ns/10ps

module dma_apb_regs (
    input  logic                        CLK,
    input  logic                        RSTN,
    input  logic                        PSEL,
    input  logic                        PENABLE,
    input  logic                        PWRITE,
    input  logic [dma_pkg::PADDR_W-1:0] PADDR,
    input  logic [dma_pkg::DATA_W-1:0]  PWDATA,
    input  logic                        done,
    output logic                        PREADY,
    output logic [dma_pkg::DATA_W-1:0]  PRDATA,
    output logic                        INTR,
    output dma_pkg::dma_addr_u          src,
    output dma_pkg::dma_addr_u          dst,
    output logic [dma_pkg::SIZE_W-1:0]  size,
    output logic                        start
);

    logic                       access;
    logic                       wr_en;
    logic                       mode;        // busy while a transfer runs
    logic                       int_done;    // sticky
    logic [dma_pkg::DATA_W-1:0] rdata;

    // one effective cycle per APB access
    assign access = PSEL & PENABLE & ~PREADY;
    assign wr_en  = access & PWRITE;
    assign start  = wr_en && PADDR == dma_pkg::REG_MODE && PWDATA == 'd1 && !mode;

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            PREADY   <= 1'b0;
            INTR     <= 1'b0;
            mode     <= 1'b0;
            int_done <= 1'b0;
            src      <= '0;
            dst      <= '0;
            size     <= '0;
        end else begin
            PREADY <= access;
            INTR   <= done;
            if (wr_en && !mode) begin    // config locked while busy
                case (PADDR)
                    dma_pkg::REG_SRC:  src.raw <= PWDATA;
                    dma_pkg::REG_DST:  dst.raw <= PWDATA;
                    dma_pkg::REG_SIZE: size    <= PWDATA[dma_pkg::SIZE_W-1:0];
                    default: ;
                endcase
            end
            if (wr_en && PADDR == dma_pkg::REG_INT && PWDATA[0])
                int_done <= 1'b0;
            if (start)
                mode <= 1'b1;
            if (done) begin    // completion wins over a clear
                mode     <= 1'b0;
                int_done <= 1'b1;
            end
        end
    end

    always_comb begin
        case (PADDR)
            dma_pkg::REG_SRC:  rdata = src.raw;
            dma_pkg::REG_DST:  rdata = dst.raw;
            dma_pkg::REG_SIZE: rdata = {{(dma_pkg::DATA_W-dma_pkg::SIZE_W){1'b0}}, size};
            dma_pkg::REG_MODE: rdata = {{(dma_pkg::DATA_W-1){1'b0}}, mode};
            dma_pkg::REG_INT:  rdata = {{(dma_pkg::DATA_W-1){1'b0}}, int_done};
            default:           rdata = '0;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (access && !PWRITE)
            PRDATA <= rdata;
    end

    // busy right after a start
    start_busy_a : assert property (@(posedge CLK) disable iff (!RSTN)
        start |=> mode);

endmodule

/* rtl/dma_read_engine.sv */
`timescale 1ns/10ps

module dma_read_engine (
    input  logic                           CLK,
    input  logic                           RSTN,
    input  logic                           start,
    input  dma_pkg::dma_addr_u             src,
    input  dma_pkg::dma_addr_u             dst,
    input  logic [dma_pkg::SIZE_W-1:0]     size,
    input  logic                           rd_gnt,
    input  logic                           rd_valid,
    input  logic [dma_pkg::DATA_W-1:0]     rd_data,
    input  logic [dma_pkg::FIFO_LVL_W-1:0] fifo_level,
    output logic                           rd_req,
    output logic                           rd_bank,
    output logic [dma_pkg::WORD_AW-1:0]    rd_addr,
    output logic                           push,
    output logic [dma_pkg::DATA_W-1:0]     push_data
);

    logic                        active;
    logic                        inflight;
    logic                        first;         // first source word
    logic [dma_pkg::SIZE_W-1:0]  reads_left;
    logic [dma_pkg::SIZE_W-1:0]  bytes_left;
    logic [dma_pkg::WORD_AW-1:0] rd_word;
    logic [dma_pkg::SIZE_W:0]    src_span;
    logic [2:0]                  acc_cnt;       // bytes held, up to 7
    logic [55:0]                 acc_data;
    logic [55:0]                 merged;
    logic [1:0]                  skip;
    logic [2:0]                  avail;
    logic [2:0]                  take;
    logic [2:0]                  sum;
    logic                        flush;

    assign src_span = {1'b0, size} + (dma_pkg::SIZE_W+1)'(src.f.offset)
                    + (dma_pkg::SIZE_W+1)'(3);

    assign skip  = first ? src.f.offset : 2'd0;
    assign avail = 3'd4 - {1'b0, skip};
    assign take  = (bytes_left < dma_pkg::SIZE_W'(avail)) ? bytes_left[2:0] : avail;
    assign sum   = acc_cnt + take;
    assign flush = active && reads_left == '0 && !inflight && acc_cnt != 3'd0;

    // keep room for the returning word plus the tail flush
    assign rd_req  = active && reads_left != '0 && !inflight
                  && fifo_level <= dma_pkg::FIFO_DEPTH - 2;
    assign rd_bank = src.f.bank;
    assign rd_addr = rd_word;

    assign push      = (rd_valid && sum >= 3'd4) || flush;
    assign push_data = flush ? acc_data[31:0] : merged[31:0];

    // append the valid source bytes behind what is held
    always_comb begin
        merged = acc_data;
        for (int i = 0; i < 7; i++) begin
            if (i >= acc_cnt && i < acc_cnt + take)
                merged[8*i +: 8] = rd_data[8*(i - acc_cnt + skip) +: 8];
        end
    end

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            active     <= 1'b0;
            inflight   <= 1'b0;
            first      <= 1'b0;
            reads_left <= '0;
            bytes_left <= '0;
            rd_word    <= '0;
            acc_cnt    <= '0;
        end else if (start) begin
            active     <= size != '0;
            inflight   <= 1'b0;
            first      <= 1'b1;
            reads_left <= dma_pkg::SIZE_W'(src_span >> 2);
            bytes_left <= size;
            rd_word    <= src.f.word;
            acc_cnt    <= {1'b0, dst.f.offset};    // pad to dst lane
        end else if (active) begin
            if (rd_req && rd_gnt) begin
                inflight   <= 1'b1;
                reads_left <= reads_left - 1'b1;
                rd_word    <= rd_word + 1'b1;
            end
            if (rd_valid) begin
                inflight   <= 1'b0;
                first      <= 1'b0;
                bytes_left <= bytes_left - dma_pkg::SIZE_W'(take);
                acc_cnt    <= (sum >= 3'd4) ? sum - 3'd4 : sum;
            end
            if (flush)
                acc_cnt <= 3'd0;
            if (reads_left == '0 && !inflight && acc_cnt == 3'd0)
                active <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (rd_valid)
            acc_data <= (sum >= 3'd4) ? {32'b0, merged[55:32]} : merged;
    end

    // a granted read returns next cycle
    rd_return_a : assert property (@(posedge CLK) disable iff (!RSTN)
        rd_req && rd_gnt |=> rd_valid);

endmodule

/* rtl/dma_fifo.sv */
`timescale 1ns/10ps

module dma_fifo (
    input  logic                           CLK,
    input  logic                           RSTN,
    input  logic                           push,
    input  logic [dma_pkg::DATA_W-1:0]     push_data,
    input  logic                           pop,
    output logic [dma_pkg::DATA_W-1:0]     pop_data,
    output logic                           empty,
    output logic [dma_pkg::FIFO_LVL_W-1:0] level
);

    logic [dma_pkg::DATA_W-1:0]     mem [dma_pkg::FIFO_DEPTH];
    logic [dma_pkg::FIFO_LVL_W-2:0] wr_ptr;
    logic [dma_pkg::FIFO_LVL_W-2:0] rd_ptr;

    assign pop_data = mem[rd_ptr];    // head word shows without a pop
    assign empty    = level == '0;

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            level <= level + dma_pkg::FIFO_LVL_W'(push) - dma_pkg::FIFO_LVL_W'(pop);
        end
    end

    always_ff @(posedge CLK) begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    no_overflow_a : assert property (@(posedge CLK) disable iff (!RSTN)
        push |-> level < dma_pkg::FIFO_DEPTH);
    no_underflow_a : assert property (@(posedge CLK) disable iff (!RSTN)
        pop |-> !empty);

endmodule

/* rtl/dma_write_engine.sv */
`timescale 1ns/10ps

module dma_write_engine (
    input  logic                        CLK,
    input  logic                        RSTN,
    input  logic                        start,
    input  dma_pkg::dma_addr_u          dst,
    input  logic [dma_pkg::SIZE_W-1:0]  size,
    input  logic                        wr_gnt,
    input  logic [dma_pkg::DATA_W-1:0]  pop_data,
    input  logic                        empty,
    output logic                        wr_req,
    output logic                        wr_bank,
    output logic [dma_pkg::WORD_AW-1:0] wr_addr,
    output logic [dma_pkg::BE_W-1:0]    wr_be,
    output logic [dma_pkg::DATA_W-1:0]  wr_data,
    output logic                        pop,
    output logic                        done
);

    logic                        active;
    logic                        first;
    logic                        last;
    logic [dma_pkg::SIZE_W-1:0]  words_left;
    logic [dma_pkg::WORD_AW-1:0] wr_word;
    logic [dma_pkg::SIZE_W:0]    dst_span;
    logic [1:0]                  end_off;
    logic [dma_pkg::BE_W-1:0]    first_be;
    logic [dma_pkg::BE_W-1:0]    last_be;

    assign dst_span = {1'b0, size} + (dma_pkg::SIZE_W+1)'(dst.f.offset)
                    + (dma_pkg::SIZE_W+1)'(3);

    assign end_off  = dst.f.offset + size[1:0];
    assign first_be = dma_pkg::BE_ALL << dst.f.offset;
    assign last_be  = (end_off == 2'd0) ? dma_pkg::BE_ALL : ~(dma_pkg::BE_ALL << end_off);
    assign last     = words_left == 'd1;

    assign wr_req  = active && !empty;
    assign wr_bank = dst.f.bank;
    assign wr_addr = wr_word;
    assign wr_data = pop_data;
    assign wr_be   = (first ? first_be : dma_pkg::BE_ALL) & (last ? last_be : dma_pkg::BE_ALL);
    assign pop     = wr_req && wr_gnt;

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            active     <= 1'b0;
            first      <= 1'b0;
            words_left <= '0;
            wr_word    <= '0;
            done       <= 1'b0;
        end else begin
            done <= (start && size == '0) || (pop && last);
            if (start) begin
                active     <= size != '0;
                first      <= 1'b1;
                words_left <= dma_pkg::SIZE_W'(dst_span >> 2);
                wr_word    <= dst.f.word;
            end else if (pop) begin
                first      <= 1'b0;
                words_left <= words_left - 1'b1;
                wr_word    <= wr_word + 1'b1;
                if (last)
                    active <= 1'b0;
            end
        end
    end

    be_nonzero_a : assert property (@(posedge CLK) disable iff (!RSTN)
        wr_req |-> wr_be != dma_pkg::BE_NONE);

endmodule

/* rtl/dma_mem_arbiter.sv */
`timescale 1ns/10ps

module dma_mem_arbiter (
    input  logic                        CLK,
    input  logic                        RSTN,
    input  logic                        rd_req,
    input  logic                        rd_bank,
    input  logic [dma_pkg::WORD_AW-1:0] rd_addr,
    input  logic                        wr_req,
    input  logic                        wr_bank,
    input  logic [dma_pkg::WORD_AW-1:0] wr_addr,
    input  logic [dma_pkg::BE_W-1:0]    wr_be,
    input  logic [dma_pkg::DATA_W-1:0]  wr_data,
    input  logic [dma_pkg::DATA_W-1:0]  mem0_rdata,
    input  logic [dma_pkg::DATA_W-1:0]  mem1_rdata,
    output logic                        rd_gnt,
    output logic                        wr_gnt,
    output logic                        rd_valid,
    output logic [dma_pkg::DATA_W-1:0]  rd_data,
    output logic                        mem0_en,
    output logic [dma_pkg::BE_W-1:0]    mem0_we,
    output logic [dma_pkg::WORD_AW-1:0] mem0_addr,
    output logic [dma_pkg::DATA_W-1:0]  mem0_wdata,
    output logic                        mem1_en,
    output logic [dma_pkg::BE_W-1:0]    mem1_we,
    output logic [dma_pkg::WORD_AW-1:0] mem1_addr,
    output logic [dma_pkg::DATA_W-1:0]  mem1_wdata
);

    logic                        rd_bank_q;    // bank of the read in flight
    logic [1:0]                  port_en;
    logic [dma_pkg::BE_W-1:0]    port_we    [2];
    logic [dma_pkg::WORD_AW-1:0] port_addr  [2];
    logic [dma_pkg::DATA_W-1:0]  port_wdata [2];

    // writer always wins a shared bank
    assign wr_gnt = wr_req;
    assign rd_gnt = rd_req && !(wr_req && wr_bank == rd_bank);

    // port 0 is mem0, reached with bank bit 1
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            port_en[p]    = 1'b0;
            port_we[p]    = dma_pkg::BE_NONE;
            port_addr[p]  = rd_addr;
            port_wdata[p] = wr_data;
            if (wr_req && wr_bank == (p == 0)) begin
                port_en[p]   = 1'b1;
                port_we[p]   = wr_be;
                port_addr[p] = wr_addr;
            end else if (rd_gnt && rd_bank == (p == 0)) begin
                port_en[p] = 1'b1;
            end
        end
    end

    assign mem0_en    = port_en[0];
    assign mem0_we    = port_we[0];
    assign mem0_addr  = port_addr[0];
    assign mem0_wdata = port_wdata[0];
    assign mem1_en    = port_en[1];
    assign mem1_we    = port_we[1];
    assign mem1_addr  = port_addr[1];
    assign mem1_wdata = port_wdata[1];

    assign rd_data = rd_bank_q ? mem0_rdata : mem1_rdata;

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            rd_valid  <= 1'b0;
            rd_bank_q <= 1'b0;
        end else begin
            rd_valid <= rd_gnt;    // synchronous memory read
            if (rd_gnt)
                rd_bank_q <= rd_bank;
        end
    end

    // a read that loses the bank holds its request
    rd_hold_a : assert property (@(posedge CLK) disable iff (!RSTN)
        rd_req && !rd_gnt |=> rd_req && $stable(rd_bank) && $stable(rd_addr));

endmodule

/* rtl/dma_top.sv */
`timescale 1ns/10ps

module dma_top (
    input  logic                        CLK,
    input  logic                        RSTN,
    output logic                        INTR,
    // APB
    input  logic                        PSEL,
    input  logic                        PENABLE,
    output logic                        PREADY,
    input  logic                        PWRITE,
    input  logic [dma_pkg::PADDR_W-1:0] PADDR,
    input  logic [dma_pkg::DATA_W-1:0]  PWDATA,
    output logic [dma_pkg::DATA_W-1:0]  PRDATA,
    // memory 0
    output logic                        mem0_en,
    output logic [dma_pkg::BE_W-1:0]    mem0_we,
    output logic [dma_pkg::WORD_AW-1:0] mem0_addr,
    output logic [dma_pkg::DATA_W-1:0]  mem0_wdata,
    input  logic [dma_pkg::DATA_W-1:0]  mem0_rdata,
    // memory 1
    output logic                        mem1_en,
    output logic [dma_pkg::BE_W-1:0]    mem1_we,
    output logic [dma_pkg::WORD_AW-1:0] mem1_addr,
    output logic [dma_pkg::DATA_W-1:0]  mem1_wdata,
    input  logic [dma_pkg::DATA_W-1:0]  mem1_rdata
);

    dma_pkg::dma_addr_u                src;
    dma_pkg::dma_addr_u                dst;
    logic [dma_pkg::SIZE_W-1:0]        size;
    logic                              start;
    logic                              done;
    logic                              rd_req, rd_bank, rd_gnt, rd_valid;
    logic [dma_pkg::WORD_AW-1:0]       rd_addr;
    logic [dma_pkg::DATA_W-1:0]        rd_data;
    logic                              wr_req, wr_bank, wr_gnt;
    logic [dma_pkg::WORD_AW-1:0]       wr_addr;
    logic [dma_pkg::BE_W-1:0]          wr_be;
    logic [dma_pkg::DATA_W-1:0]        wr_data;
    logic                              push, pop, empty;
    logic [dma_pkg::DATA_W-1:0]        push_data;
    logic [dma_pkg::DATA_W-1:0]        pop_data;
    logic [dma_pkg::FIFO_LVL_W-1:0]    level;

    dma_apb_regs regs_inst (.*);

    dma_read_engine rd_inst (
        .*,
        .fifo_level (level)
    );

    dma_fifo fifo_inst (.*);

    dma_write_engine wr_inst (.*);

    dma_mem_arbiter arb_inst (.*);

endmodule

/* verif/mem_model.sv */
`timescale 1ns/10ps

module mem_model #(
    parameter int AW = 8    // words actually stored, 2**AW
) (
    input  logic                        CLK,
    input  logic                        en,
    input  logic [dma_pkg::BE_W-1:0]    we,
    input  logic [dma_pkg::WORD_AW-1:0] addr,
    input  logic [dma_pkg::DATA_W-1:0]  wdata,
    output logic [dma_pkg::DATA_W-1:0]  rdata
);

    logic [dma_pkg::DATA_W-1:0] mem [1 << AW];

    initial rdata = '0;

    // read returns the old word on a write cycle
    always @(posedge CLK) begin
        if (en) begin
            rdata <= mem[addr[AW-1:0]];
            for (int b = 0; b < dma_pkg::BE_W; b++) begin
                if (we[b])
                    mem[addr[AW-1:0]][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

endmodule

/* verif/dma_tb.sv */
`timescale 1ns/10ps

module dma_tb;

    localparam int CLK_PERIOD  = 40;
    localparam int MEM_AW      = 8;
    localparam int MEM_WORDS   = 1 << MEM_AW;
    localparam int N_ALIGNED   = 4;
    localparam int N_RANDOM    = 40;
    localparam int N_XFERS     = N_ALIGNED + N_RANDOM + 1;
    localparam int MAX_WORDS   = 13;        // offset 3 plus 48 bytes
    localparam int APB_CYCLES  = 8 * 4;     // config and status accesses
    localparam int XFER_CYCLES = 2 * MAX_WORDS + 20 + APB_CYCLES;

    logic                        CLK;
    logic                        RSTN;
    logic                        INTR;
    logic                        PSEL;
    logic                        PENABLE;
    logic                        PREADY;
    logic                        PWRITE;
    logic [dma_pkg::PADDR_W-1:0] PADDR;
    logic [dma_pkg::DATA_W-1:0]  PWDATA;
    logic [dma_pkg::DATA_W-1:0]  PRDATA;
    logic                        mem0_en;
    logic [dma_pkg::BE_W-1:0]    mem0_we;
    logic [dma_pkg::WORD_AW-1:0] mem0_addr;
    logic [dma_pkg::DATA_W-1:0]  mem0_wdata;
    logic [dma_pkg::DATA_W-1:0]  mem0_rdata;
    logic                        mem1_en;
    logic [dma_pkg::BE_W-1:0]    mem1_we;
    logic [dma_pkg::WORD_AW-1:0] mem1_addr;
    logic [dma_pkg::DATA_W-1:0]  mem1_wdata;
    logic [dma_pkg::DATA_W-1:0]  mem1_rdata;

    logic [7:0] model [2][MEM_WORDS*4];    // index 0 is mem0
    int         errors       = 0;
    int         tests_run    = 0;
    int         tests_failed = 0;
    int         intr_count   = 0;

    dma_top dma_top_inst (.*);

    mem_model #(.AW(MEM_AW)) mem0_inst (
        .CLK(CLK), .en(mem0_en), .we(mem0_we), .addr(mem0_addr),
        .wdata(mem0_wdata), .rdata(mem0_rdata)
    );

    mem_model #(.AW(MEM_AW)) mem1_inst (
        .CLK(CLK), .en(mem1_en), .we(mem1_we), .addr(mem1_addr),
        .wdata(mem1_wdata), .rdata(mem1_rdata)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    always @(negedge CLK) begin
        if (RSTN && INTR)
            intr_count++;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////
    function automatic int port_of(input bit bank);
        return bank ? 0 : 1;    // bank bit set selects mem0
    endfunction

    function automatic logic [31:0] make_addr(input bit bank, input int word, input int off);
        return (32'(bank) << 20) | (32'(word) << 2) | 32'(off);
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err0);
        tests_run++;
        if (errors != err0) begin
            tests_failed++;
            $display("test %0s: %0d mismatches", name, errors - err0);
        end else begin
            $display("test %0s: ok", name);
        end
    endtask

    task automatic apb_access(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge CLK);
        PSEL    <= 1'b1;
        PENABLE <= 1'b0;
        PWRITE  <= wr;
        PADDR   <= addr;
        PWDATA  <= wdata;
        @(posedge CLK);
        PENABLE <= 1'b1;
        do @(negedge CLK); while (!PREADY);
        rdata = PRDATA;
        @(posedge CLK);
        PSEL    <= 1'b0;
        PENABLE <= 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
        apb_access(1'b0, addr, 32'd0, data);
    endtask

    task automatic preload_memories();
        logic [31:0] d0;
        logic [31:0] d1;
        for (int w = 0; w < MEM_WORDS; w++) begin
            d0 = $urandom;
            d1 = $urandom;
            mem0_inst.mem[w] = d0;
            mem1_inst.mem[w] = d1;
            for (int b = 0; b < 4; b++) begin
                model[0][4*w+b] = d0[8*b +: 8];
                model[1][4*w+b] = d1[8*b +: 8];
            end
        end
    endtask

    task automatic compare_memories(input string name);
        logic [31:0] exp;
        logic [31:0] act;
        for (int p = 0; p < 2; p++) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                exp = {model[p][4*w+3], model[p][4*w+2], model[p][4*w+1], model[p][4*w]};
                act = (p == 0) ? mem0_inst.mem[w] : mem1_inst.mem[w];
                check($sformatf("%s mem%0d word %0d", name, p, w), exp, act);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////
    task automatic verify_reset_outputs();
        int err0;
        err0 = errors;
        @(negedge CLK);
        check("reset outputs", 32'd0,
              32'({INTR, PREADY, mem0_en, mem1_en, mem0_we, mem1_we}));
        finish_test("reset", err0);
    endtask

    task automatic test_registers();
        logic [31:0] src_v;
        logic [31:0] dst_v;
        logic [31:0] size_v;
        logic [31:0] rd;
        int          err0;
        err0   = errors;
        src_v  = $urandom;
        dst_v  = $urandom;
        size_v = $urandom & 32'h0000_ffff;
        apb_write(dma_pkg::REG_SRC, src_v);
        apb_write(dma_pkg::REG_DST, dst_v);
        apb_write(dma_pkg::REG_SIZE, size_v);
        apb_read(dma_pkg::REG_SRC, rd);
        check("registers src", src_v, rd);
        apb_read(dma_pkg::REG_DST, rd);
        check("registers dst", dst_v, rd);
        apb_read(dma_pkg::REG_SIZE, rd);
        check("registers size", size_v, rd);
        apb_read(32'h0000_0014, rd);
        check("registers unmapped", 32'd0, rd);
        apb_read(dma_pkg::REG_MODE, rd);
        check("registers mode idle", 32'd0, rd);
        finish_test("registers", err0);
    endtask

    task automatic run_transfer(input string name, input bit sbank, input int sword,
                                input int soff, input bit dbank, input int dword,
                                input int doff, input int size);
        logic [31:0] rd;
        int          err0;
        int          intr0;
        err0  = errors;
        intr0 = intr_count;
        for (int k = 0; k < size; k++)
            model[port_of(dbank)][4*dword+doff+k] = model[port_of(sbank)][4*sword+soff+k];
        apb_write(dma_pkg::REG_SRC, make_addr(sbank, sword, soff));
        apb_write(dma_pkg::REG_DST, make_addr(dbank, dword, doff));
        apb_write(dma_pkg::REG_SIZE, 32'(size));
        apb_write(dma_pkg::REG_MODE, 32'd1);
        while (intr_count == intr0)
            @(negedge CLK);
        apb_read(dma_pkg::REG_MODE, rd);
        check({name, " mode"}, 32'd0, rd);
        apb_read(dma_pkg::REG_INT, rd);
        check({name, " int set"}, 32'd1, rd);
        apb_write(dma_pkg::REG_INT, 32'd1);
        apb_read(dma_pkg::REG_INT, rd);
        check({name, " int cleared"}, 32'd0, rd);
        check({name, " intr pulses"}, 32'(intr0 + 1), 32'(intr_count));
        compare_memories(name);
        finish_test(name, err0);
    endtask

    initial begin
        void'($urandom(10));
        RSTN    = 1'b0;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
        PADDR   = '0;
        PWDATA  = '0;
        preload_memories();
        repeat (3) @(posedge CLK);
        RSTN <= 1'b1;
        verify_reset_outputs();
        test_registers();
        for (int i = 0; i < N_ALIGNED; i++) begin
            bit sb;
            sb = $urandom % 2;
            run_transfer($sformatf("aligned_%0d", i), sb, $urandom % 100, 0,
                         !sb, 128 + $urandom % 100, 0, 4 * (1 + $urandom % 12));
        end
        // low and high regions never overlap, so same-bank copies are safe
        for (int i = 0; i < N_RANDOM; i++) begin
            int lo;
            int hi;
            bit swap;
            lo   = $urandom % 100;
            hi   = 128 + $urandom % 100;
            swap = $urandom % 2;
            run_transfer($sformatf("misaligned_%0d", i), $urandom % 2, swap ? hi : lo,
                         $urandom % 4, $urandom % 2, swap ? lo : hi, $urandom % 4,
                         1 + $urandom % 48);
        end
        run_transfer("zero_size", 1'b1, 10, 1, 1'b0, 140, 2, 0);
        check("total intr pulses", 32'(N_XFERS), 32'(intr_count));
        $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    // watchdog
    initial begin
        repeat ((N_XFERS + 2) * XFER_CYCLES) @(posedge CLK);
        $display("timeout: transfers did not finish within %0d cycles",
                 (N_XFERS + 2) * XFER_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* sim.f */
rtl/dma_pkg.sv
rtl/dma_apb_regs.sv
rtl/dma_read_engine.sv
rtl/dma_fifo.sv
rtl/dma_write_engine.sv
rtl/dma_mem_arbiter.sv
rtl/dma_top.sv
verif/mem_model.sv
verif/dma_tb.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing -Wno-fatal
TOP   = dma_tb
FLIST = sim.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF "*** PASSED ***"

clean:
	rm -rf obj_dir
